/* hdl/imul_pkg.sv */
/*
 * Multiplier farm shared types
 * Operand, product and shift widths plus the lane FSM encoding
 */

package imul_pkg;

  // ------------------------------------------------------------
  // Datapath widths
  // ------------------------------------------------------------

  // Multiplicand or multiplier
  typedef logic [31:0] operand_t;

  // Low half of a product
  typedef logic [31:0] product_t;

  // One calculation step moves 1 to 32 bit positions
  typedef logic [5:0] shamt_t;

  // ------------------------------------------------------------
  // Lane FSM
  // ------------------------------------------------------------

  typedef enum logic [1:0] {
    idle,
    calc,
    done
  } lane_state_t;

endpackage

/* hdl/imul_lane_if.sv */
/*
 * Lane link between dispatcher, one multiplier lane and collector
 */

interface imul_lane_if
  import imul_pkg::*;
();

  // Issue side
  logic     issue;
  operand_t a;
  operand_t b;

  // Result side
  logic     done;
  product_t result;
  logic     pop;

  // Lane is free again
  logic     credit;

  modport dispatch (
    output issue, a, b,
    input  credit
  );

  modport lane (
    input  issue, a, b, pop,
    output done, result, credit
  );

  modport collect (
    input  done, result,
    output pop
  );

endinterface

/* hdl/imul_dispatch.sv */
/*
 * Request dispatcher for the multiplier farm
 * Round-robin issue to lanes with one credit each
 */

module imul_dispatch
  import imul_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_valid,
  output logic     req_ready,
  input  operand_t req_a,
  input  operand_t req_b,
  imul_lane_if.dispatch lanes [NUM_LANES]
);

  localparam int LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [LANE_IDX_W-1:0] issue_ptr;
  logic [NUM_LANES-1:0]  credits;
  logic [NUM_LANES-1:0]  credit_in;
  logic [NUM_LANES-1:0]  spend;
  logic [NUM_LANES-1:0]  issue_q;
  operand_t              a_q;
  operand_t              b_q;
  logic                  req_fire;

  // Ready only when the lane under the pointer is free
  assign req_ready = credits[issue_ptr];
  assign req_fire  = req_valid && req_ready;

  // One-hot credit spend for the lane being issued
  always_comb begin
    spend = '0;
    if (req_fire) spend[issue_ptr] = 1'b1;
  end

  // ------------------------------------------------------------
  // Credits, pointer and issue pulses
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      credits   <= '1;
      issue_ptr <= '0;
      issue_q   <= '0;
    end else begin
      // Spend and restore never hit the same lane together
      credits <= (credits & ~spend) | credit_in;
      issue_q <= spend;
      if (req_fire) begin
        if (issue_ptr == LANE_IDX_W'(NUM_LANES - 1)) issue_ptr <= '0;
        else issue_ptr <= issue_ptr + 1'b1;
      end
    end
  end

  // Operand hold register shared by all lanes
  always_ff @(posedge clk) begin
    if (req_fire) begin
      a_q <= req_a;
      b_q <= req_b;
    end
  end

  // Fan out to the lane links
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    assign lanes[i].issue = issue_q[i];
    assign lanes[i].a     = a_q;
    assign lanes[i].b     = b_q;
    assign credit_in[i]   = lanes[i].credit;

    // Lane returns a credit only after it was taken
    assert property (@(posedge clk) disable iff (reset)
      credit_in[i] |-> !credits[i]);

    // Issued lane has spent its credit and returns none yet
    assert property (@(posedge clk) disable iff (reset)
      issue_q[i] |-> !credits[i] && !credit_in[i]);
  end

endmodule

/* hdl/imul_var_lat_lane.sv */
/*
 * Variable-latency shift-and-add multiplier lane
 * Skips zero runs in the multiplier and holds the product until popped
 */

module imul_var_lat_lane
  import imul_pkg::*;
(
  input logic clk,
  input logic reset,
  imul_lane_if.lane lane
);

  lane_state_t state;
  operand_t    a_reg;
  operand_t    b_reg;
  product_t    acc;
  shamt_t      shift_cnt;
  shamt_t      tz_cnt;
  shamt_t      shamt;
  shamt_t      cnt_sum;
  logic        calc_last;
  logic        credit_q;

  // ------------------------------------------------------------
  // Step size
  // ------------------------------------------------------------

  // Trailing zero count of b, lowest set bit wins
  // All zero b gives the full 32
  always_comb begin
    tz_cnt = 6'd32;
    for (int i = 31; i >= 0; i--) begin
      if (b_reg[i]) tz_cnt = shamt_t'(i);
    end
  end

  // Add step moves one bit, skip step jumps the whole zero run
  assign shamt = b_reg[0] ? 6'd1 : tz_cnt;

  // Count stays below 32 in calc so the sum fits in 6 bits
  assign cnt_sum   = shift_cnt + shamt;
  assign calc_last = cnt_sum[5];

  // ------------------------------------------------------------
  // Control FSM
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      shift_cnt <= '0;
      credit_q  <= 1'b0;
    end else begin
      credit_q <= 1'b0;
      case (state)
        idle: begin
          if (lane.issue) begin
            state     <= calc;
            shift_cnt <= '0;
          end
        end
        calc: begin
          shift_cnt <= cnt_sum;
          if (calc_last) state <= done;
        end
        done: begin
          // Credit goes back the cycle after the pop
          if (lane.pop) begin
            state    <= idle;
            credit_q <= 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (state == idle && lane.issue) begin
      a_reg <= lane.a;
      b_reg <= lane.b;
      acc   <= '0;
    end else if (state == calc) begin
      // Accumulate before the shift when the low bit is set
      if (b_reg[0]) acc <= acc + a_reg;
      a_reg <= a_reg << shamt;
      b_reg <= b_reg >> shamt;
    end
  end

  // Outputs
  assign lane.done   = (state == done);
  assign lane.result = acc;
  assign lane.credit = credit_q;

  // Dispatcher must respect the credit
  assert property (@(posedge clk) disable iff (reset)
    lane.issue |-> state == idle);

  // Collector only pops a held result
  assert property (@(posedge clk) disable iff (reset)
    lane.pop |-> state == done);

endmodule

/* hdl/imul_collect.sv */
/*
 * Response collector for the multiplier farm
 * Drains lanes in round-robin order so products leave in request order
 */

module imul_collect
  import imul_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic     clk,
  input  logic     reset,
  imul_lane_if.collect lanes [NUM_LANES],
  output logic     resp_valid,
  input  logic     resp_ready,
  output product_t resp_result
);

  localparam int LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [LANE_IDX_W-1:0] drain_ptr;
  logic [NUM_LANES-1:0]  done_vec;
  logic [NUM_LANES-1:0]  pop_vec;
  product_t              result_arr [NUM_LANES];
  logic                  resp_fire;

  // Gather lane outputs, scatter pops
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    assign done_vec[i]   = lanes[i].done;
    assign result_arr[i] = lanes[i].result;
    assign pop_vec[i]    = resp_fire && (drain_ptr == LANE_IDX_W'(i));
    assign lanes[i].pop  = pop_vec[i];
  end

  // Response straight from the lane under the pointer
  assign resp_valid  = done_vec[drain_ptr];
  assign resp_result = result_arr[drain_ptr];
  assign resp_fire   = resp_valid && resp_ready;

  // Drain pointer follows the dispatcher's issue order
  always_ff @(posedge clk) begin
    if (reset) begin
      drain_ptr <= '0;
    end else if (resp_fire) begin
      if (drain_ptr == LANE_IDX_W'(NUM_LANES - 1)) drain_ptr <= '0;
      else drain_ptr <= drain_ptr + 1'b1;
    end
  end

  // Held response stays put under back-pressure
  assert property (@(posedge clk) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_result));

endmodule

/* hdl/imul_farm_top.sv */
/*
 * Multiplier farm top level
 * Dispatcher, NUM_LANES variable-latency lanes and an in-order collector
 */

module imul_farm_top
  import imul_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_valid,
  output logic     req_ready,
  input  operand_t req_a,
  input  operand_t req_b,
  output logic     resp_valid,
  input  logic     resp_ready,
  output product_t resp_result
);

  // One link per lane
  imul_lane_if lane_if [NUM_LANES] ();

  imul_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) dispatch_inst (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_a     (req_a),
    .req_b     (req_b),
    .lanes     (lane_if)
  );

  // Identical lanes
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    imul_var_lat_lane lane_inst (
      .clk   (clk),
      .reset (reset),
      .lane  (lane_if[i])
    );
  end

  imul_collect #(
    .NUM_LANES (NUM_LANES)
  ) collect_inst (
    .clk         (clk),
    .reset       (reset),
    .lanes       (lane_if),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .resp_result (resp_result)
  );

endmodule

/* verification/imul_farm_tb.sv */
/*
 * Testbench for the multiplier farm
 * Vector-driven requests with random gaps and back-pressure, in-order scoreboard
 */

module imul_farm_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_LANES      = 4;
  localparam int NUM_VEC        = 22;
  localparam int TOTAL_REQ      = 3 * NUM_VEC;
  localparam int WAIT_LIMIT     = 200;
  localparam int RUN_LIMIT      = 5000;
  localparam int OBSERVE_CYCLES = 40;

  logic        clk;
  logic        reset;
  logic        req_valid;
  logic        req_ready;
  logic [31:0] req_a;
  logic [31:0] req_b;
  logic        resp_valid;
  logic        resp_ready;
  logic [31:0] resp_result;

  // Three words per vector: a, b, product
  logic [31:0] vec_mem [0:3*NUM_VEC-1];

  // Expected products in request order
  logic [31:0] exp_q [$];

  logic [31:0] lfsr_state;
  logic [31:0] offered_exp;
  logic [31:0] held_result;
  logic        req_taken;
  logic        resp_held;
  int          next_req;
  int          n_accepted;
  int          n_resp;
  int          n_checks;
  int          n_errors;
  int          n_timeouts;
  int          loops;

  imul_farm_top #(
    .NUM_LANES (NUM_LANES)
  ) imul_farm_top_inst (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .resp_result (resp_result)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Random bits, checks and timeouts
  // ------------------------------------------------------------

  // Galois LFSR, taps x^32 + x^30 + x^26 + x^25 + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) nxt = nxt ^ 32'hA300_0000;
    return nxt;
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      $display("** Error: %s expected %08h actual %08h", name, expected, actual);
      n_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    n_timeouts++;
  endtask

  // ------------------------------------------------------------
  // One clock of stimulus on both ports
  // ------------------------------------------------------------

  task automatic drive_cycle(input logic hold_resp);
    int idx;
    @(negedge clk);
    // Stalled response must not move
    if (resp_held) begin
      check_value("held resp_valid", 32'd1, 32'(resp_valid));
      check_value("held resp_result", held_result, resp_result);
    end
    // Request went in at the last rising edge
    if (req_taken) begin
      req_valid = 1'b0;
      req_taken = 1'b0;
    end
    // New request, one in four cycles left idle
    if (!req_valid && next_req < TOTAL_REQ) begin
      if (take_bits(2) != 0) begin
        idx         = next_req % NUM_VEC;
        req_valid   = 1'b1;
        req_a       = vec_mem[3*idx];
        req_b       = vec_mem[3*idx+1];
        offered_exp = vec_mem[3*idx+2];
        next_req++;
      end
    end
    // Transfer at the coming rising edge
    if (req_valid && req_ready) begin
      exp_q.push_back(offered_exp);
      n_accepted++;
      req_taken = 1'b1;
    end
    if (hold_resp) begin
      resp_ready = 1'b0;
    end else begin
      resp_ready = (take_bits(2) != 0);
    end
    if (resp_valid && resp_ready) begin
      if (exp_q.size() == 0) begin
        $display("Error: response %08h came with no request outstanding", resp_result);
        n_errors++;
      end else begin
        check_value("response product", exp_q.pop_front(), resp_result);
      end
      n_resp++;
    end
    resp_held   = resp_valid && !resp_ready;
    held_result = resp_result;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    lfsr_state  = 32'h6fc6;
    reset       = 1'b1;
    req_valid   = 1'b0;
    req_a       = '0;
    req_b       = '0;
    resp_ready  = 1'b0;
    req_taken   = 1'b0;
    resp_held   = 1'b0;
    offered_exp = '0;
    held_result = '0;
    next_req    = 0;
    n_accepted  = 0;
    n_resp      = 0;
    n_checks    = 0;
    n_errors    = 0;
    n_timeouts  = 0;
    $readmemh("verification/imul_vectors.txt", vec_mem);

    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("reset req_ready", 32'd1, 32'(req_ready));
    check_value("reset resp_valid", 32'd0, 32'(resp_valid));

    // Fill every lane with the response port stalled
    loops = 0;
    while (n_accepted < NUM_LANES && loops < WAIT_LIMIT) begin
      drive_cycle(1'b1);
      loops++;
    end
    if (n_accepted < NUM_LANES) report_timeout("lanes did not take one request each");

    loops = 0;
    while (!resp_valid && loops < WAIT_LIMIT) begin
      drive_cycle(1'b1);
      loops++;
    end
    if (!resp_valid) report_timeout("no product became valid while stalled");

    // Full farm keeps refusing
    repeat (OBSERVE_CYCLES) drive_cycle(1'b1);
    check_value("accepted while full", 32'(NUM_LANES), 32'(n_accepted));
    check_value("req_ready while full", 32'd0, 32'(req_ready));

    // Random traffic on both ports
    loops = 0;
    while (n_resp < TOTAL_REQ && loops < RUN_LIMIT) begin
      drive_cycle(1'b0);
      loops++;
    end
    if (n_resp < TOTAL_REQ) report_timeout("responses stopped before every request was answered");

    // Quiet tail, any stray product is an error
    repeat (20) drive_cycle(1'b0);
    check_value("request count", 32'(TOTAL_REQ), 32'(n_accepted));
    check_value("response count", 32'(TOTAL_REQ), 32'(n_resp));
    check_value("scoreboard left", 32'd0, 32'(exp_q.size()));

    $display("Checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
hdl/imul_pkg.sv
hdl/imul_lane_if.sv
hdl/imul_dispatch.sv
hdl/imul_var_lat_lane.sv
hdl/imul_collect.sv
hdl/imul_farm_top.sv
verification/imul_farm_tb.sv

/* run.sh */
#!/bin/sh
# Build the multiplier farm testbench with Verilator, run it, pass only on TEST OK
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module imul_farm_tb -Mdir obj_dir -o imul_farm_sim \
  && ./obj_dir/imul_farm_sim | tee /dev/stderr | grep -q "^TEST OK$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verification/imul_vectors.txt */
// Columns: multiplicand a, multiplier b, expected low 32 bits of a*b
// All values hex, one request per line
00000000 00000000 00000000
12345678 00000000 00000000
00000000 deadbeef 00000000
00000001 00000001 00000001
deadbeef 00000001 deadbeef
00000001 deadbeef deadbeef
ffffffff ffffffff 00000001
ffffffff 00000002 fffffffe
00000001 80000000 80000000
00000003 80000000 80000000
12345678 00010000 56780000
0000abcd 00010001 abcdabcd
00001234 00001000 01234000
0000ffff 0000ffff fffe0001
00010000 00010000 00000000
00000007 00000006 0000002a
87654321 00000010 76543210
00000123 00000456 0004edc2
11111111 0000000f ffffffff
00000100 01000001 00000100
00000005 7fffffff 7ffffffb
0000c0de 00000031 0024ea7e
